//--- mmio_tieoff_cases.txt
# name fmttype length requester_id tag addr_hi addr_lo beats lower_addr first_payload
# All fields hex except beats, which is decimal, and beats 0 marks a dropped write
rd32_feature_1dw   00 001 0100 01 00000000 00000000 1 00 3000000000001000
rd32_feature_2dw   00 002 0100 02 00001000 00000000 1 00 3000000000001000
rd32_signature     00 002 0abc 10 00000010 00000000 1 10 d15ab1ed00000000
rd32_sig_upper_dw  00 001 0abc 11 00000014 00000000 1 14 d15ab1ed00000000
rd32_zero_qw1      00 002 0233 20 00000008 00000000 1 08 0000000000000000
rd32_zero_qw8      00 001 0233 21 00000040 00000000 1 40 0000000000000000
rd32_alias_0x90    00 002 0233 22 00000090 00000000 1 10 d15ab1ed00000000
rd64_signature     20 001 1f00 30 00000001 00000010 1 10 d15ab1ed00000000
rd64_ignores_hi    20 002 1f00 31 00000010 00000008 1 08 0000000000000000
rd64_feature       20 002 1f00 32 00000010 00000000 1 00 3000000000001000
rd32_len3          00 003 0042 40 00000000 00000000 2 00 3000000000001000
rd32_len8          00 008 0042 41 00000010 00000000 4 10 d15ab1ed00000000
rd64_len5          20 005 0042 42 00000002 00000048 3 48 0000000000000000
wr32_dropped       40 001 0005 50 00000000 00000000 0 00 0000000000000000
rd32_after_wr32    00 002 0005 51 00000010 00000000 1 10 d15ab1ed00000000
wr64_dropped       60 002 0005 52 00000000 00000010 0 00 0000000000000000
rd64_after_wr64    20 001 0005 53 00000000 00000000 1 00 3000000000001000
rd32_len16         00 010 beef ff 0000007c 00000000 8 7c 0000000000000000

//--- mmio_tieoff.f
+incdir+.
mmio_tieoff_pkg.sv
tlp_req_capture.sv
cpl_hdr_builder.sv
mmio_read_data.sv
cpl_assembler.sv
mmio_tieoff_top.sv
tb_mmio_tieoff.sv

//--- tb_mmio_tieoff.sv
// Testbench for the PCIe MMIO tie-off responder
// Sends request headers from the case file and checks every completion beat
// against the expected header, payload and beat count while tx_ready is
// throttled by a pseudo-random sequence

`timescale 1ns/1ns

`include "mmio_tieoff_defs.svh"

module tb_mmio_tieoff;

    // Cycles any single wait may take before it counts as hung
    localparam int WAIT_LIMIT = 200;

    logic                      clk;
    logic                      reset_n;
    logic                      rx_valid;
    mmio_tieoff_pkg::rx_beat_t rx_beat;
    logic                      rx_ready;
    logic                      tx_valid;
    mmio_tieoff_pkg::tx_beat_t tx_beat;
    logic                      tx_ready;

    logic [31:0] rng_state;
    string       test_name;
    int          check_count;
    int          mismatch_count;
    int          timeout_count;
    int          other_errors;

    mmio_tieoff_top DUT
    (
        .clk      (clk),
        .reset_n  (reset_n),
        .rx_valid (rx_valid),
        .rx_beat  (rx_beat),
        .rx_ready (rx_ready),
        .tx_valid (tx_valid),
        .tx_beat  (tx_beat),
        .tx_ready (tx_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Draws tx_ready for the coming edge and keeps it high about three cycles in four
    task automatic throttle_tx();
        rng_state = xorshift32(rng_state);
        tx_ready  = (rng_state[1:0] != 2'b00);
    endtask

    task automatic check_hdr(input string what, input mmio_tieoff_pkg::cpl_hdr_t exp,
                             input mmio_tieoff_pkg::cpl_hdr_t act);
        check_count++;
        if (act !== exp)
        begin
            mismatch_count++;
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_payload(input string what, input logic [`TLP_PAYLOAD_W-1:0] exp,
                                 input logic [`TLP_PAYLOAD_W-1:0] act);
        check_count++;
        if (act !== exp)
        begin
            mismatch_count++;
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_beats(input string what, input int exp, input int act);
        check_count++;
        if (act != exp)
        begin
            mismatch_count++;
            $display("mismatch %s %s: expected %0d actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        check_count++;
        if (act !== exp)
        begin
            mismatch_count++;
            $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timeout in %s: %s did not happen within %0d cycles",
                 test_name, what, WAIT_LIMIT);
    endtask

    // Runs one request through the DUT and makes every decision at a falling edge
    task automatic run_case(input logic [7:0] fmt, input logic [9:0] len,
                            input logic [15:0] rid, input logic [7:0] tag,
                            input logic [31:0] a_hi, input logic [31:0] a_lo,
                            input int exp_beats, input logic [6:0] exp_lo,
                            input logic [`TLP_PAYLOAD_W-1:0] exp_data);
        mmio_tieoff_pkg::cpl_hdr_t exp_hdr;
        mmio_tieoff_pkg::tx_beat_t held_beat;
        logic stalled;
        logic done;
        int   beats;
        int   waited;

        // A successful CplD returns the full length and counts it in bytes
        exp_hdr              = '0;
        exp_hdr.fmttype      = mmio_tieoff_pkg::CPLD;
        exp_hdr.length       = len;
        exp_hdr.byte_count   = len * 12'd4;
        exp_hdr.requester_id = rid;
        exp_hdr.tag          = tag;
        exp_hdr.lower_addr   = exp_lo;
        held_beat            = '0;

        // Time already stands at a falling edge, so the request goes out at once
        // and follows the previous one back to back
        rx_valid                 = 1'b1;
        rx_beat.hdr.fmttype      = mmio_tieoff_pkg::tlp_fmttype_e'(fmt);
        rx_beat.hdr.length       = len;
        rx_beat.hdr.requester_id = rid;
        rx_beat.hdr.tag          = tag;
        rx_beat.hdr.addr_hi      = a_hi;
        rx_beat.hdr.addr_lo      = a_lo;
        waited = 0;
        while (!rx_ready && waited < WAIT_LIMIT)
        begin
            @(negedge clk);
            throttle_tx();
            waited++;
        end
        if (!rx_ready)
        begin
            report_timeout("request acceptance");
            rx_valid = 1'b0;
            return;
        end
        // The request transfers on this rising edge
        @(posedge clk);
        @(negedge clk);
        rx_valid = 1'b0;
        rx_beat  = '0;
        throttle_tx();

        if (exp_beats == 0)
        begin
            // A write blocks the receive side for exactly one cycle
            check_flag("rx_ready while write is dropped", 1'b0, rx_ready);
            beats = tx_valid;
            @(negedge clk);
            throttle_tx();
            beats += tx_valid;
            check_beats("beats for a write", 0, beats);
            check_flag("rx_ready after write drop", 1'b1, rx_ready);
        end
        else
        begin
            // Header and data come straight from the held request
            check_flag("tx_valid right after accept", 1'b1, tx_valid);
            stalled = 1'b0;
            done    = 1'b0;
            beats   = 0;
            waited  = 0;
            while (!done && waited < WAIT_LIMIT)
            begin
                if (stalled)
                begin
                    check_flag("tx_valid held while stalled", 1'b1, tx_valid);
                    check_hdr("stalled header", held_beat.hdr, tx_beat.hdr);
                    check_payload("stalled payload", held_beat.payload, tx_beat.payload);
                    check_flag("stalled sop", held_beat.sop, tx_beat.sop);
                    check_flag("stalled eop", held_beat.eop, tx_beat.eop);
                end
                stalled = 1'b0;
                if (tx_valid)
                begin
                    check_flag("rx_ready while busy", 1'b0, rx_ready);
                    if (tx_ready)
                    begin
                        check_hdr("header", exp_hdr, tx_beat.hdr);
                        check_payload("payload", (beats == 0) ? exp_data : '0,
                                      tx_beat.payload);
                        check_flag("sop", beats == 0, tx_beat.sop);
                        check_flag("eop", beats == exp_beats - 1, tx_beat.eop);
                        beats++;
                        done = tx_beat.eop;
                    end
                    else
                    begin
                        stalled   = 1'b1;
                        held_beat = tx_beat;
                    end
                end
                @(negedge clk);
                throttle_tx();
                waited++;
            end
            if (!done)
            begin
                report_timeout("eop transfer");
            end
            check_beats("beat count", exp_beats, beats);
            check_flag("rx_ready after completion", 1'b1, rx_ready);
            check_flag("tx_valid after completion", 1'b0, tx_valid);
        end
    endtask

    initial
    begin
        int                        fd;
        int                        n;
        int                        cases_run;
        string                     line;
        string                     name;
        logic [7:0]                fmt;
        logic [9:0]                len;
        logic [15:0]               rid;
        logic [7:0]                tag;
        logic [31:0]               a_hi;
        logic [31:0]               a_lo;
        int                        exp_beats;
        logic [6:0]                exp_lo;
        logic [`TLP_PAYLOAD_W-1:0] exp_data;

        rng_state      = 32'h5640b3be;
        reset_n        = 1'b0;
        rx_valid       = 1'b0;
        rx_beat        = '0;
        tx_ready       = 1'b0;
        check_count    = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        other_errors   = 0;
        cases_run      = 0;
        test_name      = "reset";

        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_flag("rx_ready after reset", 1'b1, rx_ready);
        check_flag("tx_valid after reset", 1'b0, tx_valid);

        fd = $fopen("mmio_tieoff_cases.txt", "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("could not open the case file mmio_tieoff_cases.txt");
        end
        else
        begin
            // Cases are read until the file ends or a wait has timed out
            while (!$feof(fd) && timeout_count == 0)
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#")
                begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %d %h %h", name, fmt, len,
                                rid, tag, a_hi, a_lo, exp_beats, exp_lo, exp_data);
                    if (n != 10)
                    begin
                        other_errors++;
                        $display("malformed line in the case file: %s", line);
                    end
                    else
                    begin
                        test_name = name;
                        run_case(fmt, len, rid, tag, a_hi, a_lo, exp_beats, exp_lo, exp_data);
                        cases_run++;
                    end
                end
            end
            $fclose(fd);
        end

        $display("cases %0d, checks %0d, mismatches %0d, timeouts %0d, other errors %0d",
                 cases_run, check_count, mismatch_count, timeout_count, other_errors);
        if (mismatch_count == 0 && timeout_count == 0 && other_errors == 0 && cases_run > 0)
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- mmio_tieoff_top.sv
// PCIe MMIO tie-off responder
// Sits on an unused host channel, answers memory reads from a small
// read-only register window and silently drops memory writes
// One request is handled at a time, the receive side stalls meanwhile

`timescale 1ns/1ns

`include "mmio_tieoff_defs.svh"

module mmio_tieoff_top
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      rx_valid,
    input  mmio_tieoff_pkg::rx_beat_t rx_beat,
    output logic                      rx_ready,
    output logic                      tx_valid,
    output mmio_tieoff_pkg::tx_beat_t tx_beat,
    input  logic                      tx_ready
);

    logic                          req_valid;
    mmio_tieoff_pkg::mem_req_hdr_t req_hdr;
    mmio_tieoff_pkg::cpl_hdr_t     cpl_hdr;
    logic [`TLP_PAYLOAD_W-1:0]     rd_data;
    logic                          cpl_done;

    // Holds the current request and throttles the receive stream
    tlp_req_capture u_capture
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .rx_valid  (rx_valid),
        .rx_beat   (rx_beat),
        .rx_ready  (rx_ready),
        .cpl_done  (cpl_done),
        .req_valid (req_valid),
        .req_hdr   (req_hdr)
    );

    // Header and data are both purely combinational from the held request
    cpl_hdr_builder u_hdr_builder
    (
        .req_hdr (req_hdr),
        .cpl_hdr (cpl_hdr)
    );

    mmio_read_data u_read_data
    (
        .req_hdr (req_hdr),
        .rd_data (rd_data)
    );

    cpl_assembler u_assembler
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .req_valid (req_valid),
        .cpl_hdr   (cpl_hdr),
        .rd_data   (rd_data),
        .tx_ready  (tx_ready),
        .tx_valid  (tx_valid),
        .tx_beat   (tx_beat),
        .cpl_done  (cpl_done)
    );

endmodule

//--- cpl_assembler.sv
// Completion assembler of the MMIO tie-off responder
// Sends the completion for the held read as one or more transmit beats
// The first beat carries the register data, later beats carry zeros
// and cpl_done pulses when the beat with eop is accepted

`timescale 1ns/1ns

`include "mmio_tieoff_defs.svh"

module cpl_assembler
(
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        req_valid,
    input  mmio_tieoff_pkg::cpl_hdr_t   cpl_hdr,
    input  logic [`TLP_PAYLOAD_W-1:0]   rd_data,
    input  logic                        tx_ready,
    output logic                        tx_valid,
    output mmio_tieoff_pkg::tx_beat_t   tx_beat,
    output logic                        cpl_done
);

    // Wide enough for ceil(1023 / 2) beats
    localparam int CNT_W = 10;

    mmio_tieoff_pkg::cpl_state_e state;
    // Beats still to send including the one on the bus, valid in SEND only
    logic [CNT_W-1:0] beats_left;
    logic [CNT_W:0]   len_round;
    logic [CNT_W-1:0] total_beats;
    logic             last_beat;
    logic             tx_xfer;

    // Number of beats in the whole completion, rounded up to full beats
    assign len_round   = {1'b0, cpl_hdr.length} + (CNT_W + 1)'(`TLP_DW_PER_BEAT - 1);
    assign total_beats = CNT_W'(len_round / `TLP_DW_PER_BEAT);

    // The request stays valid until its last beat is taken, so it also
    // covers the later beats. Header and data are ready on the same cycle
    assign tx_valid = req_valid;
    assign tx_xfer  = tx_valid && tx_ready;

    // In IDLE the first beat is on the bus and the counter is not loaded yet
    assign last_beat = (state == mmio_tieoff_pkg::IDLE) ? (total_beats <= CNT_W'(1)) :
                                                          (beats_left == CNT_W'(1));

    assign cpl_done = tx_xfer && last_beat;

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state      <= mmio_tieoff_pkg::IDLE;
            beats_left <= '0;
        end
        else if (tx_xfer)
        begin
            case (state)
                mmio_tieoff_pkg::IDLE:
                begin
                    // Single beat completions never leave IDLE
                    if (!last_beat)
                    begin
                        state      <= mmio_tieoff_pkg::SEND;
                        beats_left <= total_beats - CNT_W'(1);
                    end
                end
                default:
                begin
                    if (last_beat)
                    begin
                        state <= mmio_tieoff_pkg::IDLE;
                    end
                    beats_left <= beats_left - CNT_W'(1);
                end
            endcase
        end
    end

    always_comb
    begin
        tx_beat.hdr = cpl_hdr;
        tx_beat.sop = (state == mmio_tieoff_pkg::IDLE);
        tx_beat.eop = last_beat;

        // Only the first beat has register data behind it
        if (state == mmio_tieoff_pkg::IDLE)
        begin
            tx_beat.payload = rd_data;
        end
        else
        begin
            tx_beat.payload = '0;
        end
    end

    // A stalled beat must be offered again unchanged on the next cycle
    assert property (@(posedge clk) disable iff (!reset_n)
                     tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
        else $error("Transmit beat changed while stalled");

endmodule

//--- mmio_read_data.sv
// Read data source of the MMIO tie-off responder
// A small read-only register window decoded on qword granularity
// Qword 0 holds the feature identifier, qword 2 holds the signature in its
// upper half and every other offset reads as zero

`timescale 1ns/1ns

`include "mmio_tieoff_defs.svh"

module mmio_read_data
(
    input  mmio_tieoff_pkg::mem_req_hdr_t req_hdr,
    output logic [`TLP_PAYLOAD_W-1:0]     rd_data
);

    logic [31:0] low_addr;
    // Qword index within the 128-byte window
    logic [3:0]  qw_idx;

    assign low_addr = mmio_tieoff_pkg::req_low_addr(req_hdr);
    assign qw_idx   = low_addr[6:3];

    always_comb
    begin
        case (qw_idx)
            `MMIO_FEATURE_QW:
            begin
                rd_data = `MMIO_FEATURE_ID;
            end
            `MMIO_SIGNATURE_QW:
            begin
                // Lower dword of this register reads as zero
                rd_data = {`MMIO_SIGNATURE, {(`TLP_PAYLOAD_W - 32){1'b0}}};
            end
            default:
            begin
                rd_data = '0;
            end
        endcase
    end

endmodule

//--- cpl_hdr_builder.sv
// Completion header builder of the MMIO tie-off responder
// Turns the held read request into a successful CplD header that returns
// the requested length to the original requester

`timescale 1ns/1ns

module cpl_hdr_builder
(
    input  mmio_tieoff_pkg::mem_req_hdr_t req_hdr,
    output mmio_tieoff_pkg::cpl_hdr_t     cpl_hdr
);

    // Address dword that carries bits 6:2 for this request format
    logic [31:0] low_addr;

    assign low_addr = mmio_tieoff_pkg::req_low_addr(req_hdr);

    always_comb
    begin
        // Status stays zero since every read completes successfully
        cpl_hdr = '0;

        cpl_hdr.fmttype      = mmio_tieoff_pkg::CPLD;
        cpl_hdr.length       = req_hdr.length;
        cpl_hdr.requester_id = req_hdr.requester_id;
        cpl_hdr.tag          = req_hdr.tag;

        // The whole request is answered in one completion, so the
        // remaining byte count is the full length in bytes
        cpl_hdr.byte_count = {req_hdr.length, 2'b00};

        // Requests are dword aligned, so the two lowest bits are always zero
        cpl_hdr.lower_addr = {low_addr[6:2], 2'b00};
    end

endmodule

//--- tlp_req_capture.sv
// Request capture stage of the MMIO tie-off responder
// Accepts one request header at a time from the receive stream and holds it
// Reads stay held until their completion has left, writes are dropped
// one cycle after they are accepted

`timescale 1ns/1ns

module tlp_req_capture
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          rx_valid,
    input  mmio_tieoff_pkg::rx_beat_t     rx_beat,
    output logic                          rx_ready,
    input  logic                          cpl_done,
    output logic                          req_valid,
    output mmio_tieoff_pkg::mem_req_hdr_t req_hdr
);

    // Set while a request occupies the holding register
    logic held;
    logic rx_accept;
    logic rx_is_read;

    // Only one request is in flight, so the receive side stalls while one is held
    assign rx_ready  = !held;
    assign rx_accept = rx_valid && rx_ready;

    // Anything that is not a memory read gets no completion and is simply dropped
    assign rx_is_read = (rx_beat.hdr.fmttype == mmio_tieoff_pkg::MRD32) ||
                        (rx_beat.hdr.fmttype == mmio_tieoff_pkg::MRD64);

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            held      <= 1'b0;
            req_valid <= 1'b0;
        end
        else if (rx_accept)
        begin
            held      <= 1'b1;
            req_valid <= rx_is_read;
        end
        else if (held && (!req_valid || cpl_done))
        begin
            // A write is released right away and a read once its last beat transfers
            held      <= 1'b0;
            req_valid <= 1'b0;
        end
    end

    // Holding register for the request header, loaded on every accepted beat
    always_ff @(posedge clk)
    begin
        if (rx_accept)
        begin
            req_hdr <= rx_beat.hdr;
        end
    end

    // The sequencer can only finish a completion that this stage asked for
    assert property (@(posedge clk) disable iff (!reset_n) cpl_done |-> req_valid)
        else $error("cpl_done seen with no read request held");

endmodule

//--- mmio_tieoff_pkg.sv
// Types for the PCIe MMIO tie-off responder
// Request and completion TLP headers, the receive and transmit beats
// and the state encoding of the completion sequencer

`include "mmio_tieoff_defs.svh"

package mmio_tieoff_pkg;

    // Format and type byte of the TLPs this block handles
    // Values follow the PCIe fmt[2:0]/type[4:0] encoding
    typedef enum logic [7:0]
    {
        MRD32 = 8'h00,
        MRD64 = 8'h20,
        MWR32 = 8'h40,
        MWR64 = 8'h60,
        CPLD  = 8'h4a
    } tlp_fmttype_e;

    // Memory request header as it arrives on the receive stream
    // For the 32-bit forms addr_hi is the address and addr_lo is unused
    // For the 64-bit forms addr_hi is the upper and addr_lo the lower address
    typedef struct packed
    {
        tlp_fmttype_e fmttype;
        logic [9:0]   length;
        logic [15:0]  requester_id;
        logic [7:0]   tag;
        logic [31:0]  addr_hi;
        logic [31:0]  addr_lo;
    } mem_req_hdr_t;

    // Completion header sent back to the requester
    typedef struct packed
    {
        tlp_fmttype_e fmttype;
        logic [9:0]   length;
        // Completer status, successful completion is all zero
        logic [2:0]   cpl_status;
        logic [11:0]  byte_count;
        logic [15:0]  requester_id;
        logic [7:0]   tag;
        logic [6:0]   lower_addr;
    } cpl_hdr_t;

    // Receive beat, only the request header travels on this channel
    typedef struct packed
    {
        mem_req_hdr_t hdr;
    } rx_beat_t;

    // Transmit beat with the completion header repeated on every beat
    typedef struct packed
    {
        cpl_hdr_t                  hdr;
        logic [`TLP_PAYLOAD_W-1:0] payload;
        logic                      sop;
        logic                      eop;
    } tx_beat_t;

    // Completion sequencer states
    // IDLE also covers the first beat, SEND covers the beats after it
    typedef enum logic
    {
        IDLE = 1'b0,
        SEND = 1'b1
    } cpl_state_e;

    // Picks the dword that holds the low address bits of a request
    // The 64-bit forms carry them in the fourth header dword
    function automatic logic [31:0] req_low_addr(mem_req_hdr_t hdr);
        logic is_addr64;
        is_addr64 = (hdr.fmttype == MRD64) || (hdr.fmttype == MWR64);
        return is_addr64 ? hdr.addr_lo : hdr.addr_hi;
    endfunction

endpackage

//--- mmio_tieoff_defs.svh
// Shared constants for the PCIe MMIO tie-off responder
// Holds the stream payload width and the read-only register window contents
// that an unused host channel reports back to the host

`ifndef MMIO_TIEOFF_DEFS_SVH
`define MMIO_TIEOFF_DEFS_SVH

// Payload bits carried by one transmit beat
`define TLP_PAYLOAD_W 64

// Dwords that fit in one beat of payload
`define TLP_DW_PER_BEAT 2

// Qword index of the feature identifier register (byte offset 0x00)
`define MMIO_FEATURE_QW 4'h0

// Qword index of the signature register (byte offset 0x10)
`define MMIO_SIGNATURE_QW 4'h2

// Feature identifier returned at qword 0
// The host reads this to learn that the channel is tied off and has no AFU
`define MMIO_FEATURE_ID 64'h3000_0000_0000_1000

// Signature returned in the upper half of qword 2
`define MMIO_SIGNATURE 32'hd15a_b1ed

`endif
